/* mem_unit_pkg.sv */
package mem_unit_pkg;

    // Widths, in bits
    localparam int ADDR_BITS    = 30;
    localparam int WORD_BITS    = 32;
    localparam int TAG_BITS     = 4;
    localparam int MEM_TAG_BITS = TAG_BITS + 1;
    localparam int PERF_BITS    = 32;

    // Default scratchpad window, as word addresses
    localparam logic [ADDR_BITS-1:0] SMEM_BASE  = 30'h3F00_0000;
    localparam int                   SMEM_WORDS = 256;

    typedef struct packed {
        logic                 rw;
        logic [ADDR_BITS-1:0] addr;
        logic [WORD_BITS-1:0] data;
        logic [TAG_BITS-1:0]  tag;
    } core_req_t;

    typedef struct packed {
        logic [WORD_BITS-1:0] data;
        logic [TAG_BITS-1:0]  tag;
    } core_rsp_t;

    // Top tag bit names the source, 1 for data
    typedef struct packed {
        logic                    rw;
        logic [ADDR_BITS-1:0]    addr;
        logic [WORD_BITS-1:0]    data;
        logic [MEM_TAG_BITS-1:0] tag;
    } mem_req_t;

    typedef struct packed {
        logic [WORD_BITS-1:0]    data;
        logic [MEM_TAG_BITS-1:0] tag;
    } mem_rsp_t;

    typedef struct packed {
        logic [PERF_BITS-1:0] reads;
        logic [PERF_BITS-1:0] writes;
        logic [PERF_BITS-1:0] stalls;
        logic [PERF_BITS-1:0] latency;
    } perf_t;

endpackage

/* smem_router.sv */
`timescale 1ns/1ps

module smem_router import mem_unit_pkg::*; #(
    parameter logic [ADDR_BITS-1:0] SMEM_BASE  = mem_unit_pkg::SMEM_BASE,
    parameter int                   SMEM_WORDS = mem_unit_pkg::SMEM_WORDS
) (
    input  logic      clk,
    input  logic      reset,

    input  core_req_t in_req,
    input  logic      in_req_valid,
    output logic      in_req_ready,
    output core_rsp_t in_rsp,
    output logic      in_rsp_valid,
    input  logic      in_rsp_ready,

    output core_req_t smem_req,
    output logic      smem_req_valid,
    input  logic      smem_req_ready,
    input  core_rsp_t smem_rsp,
    input  logic      smem_rsp_valid,
    output logic      smem_rsp_ready,

    output core_req_t ext_req,
    output logic      ext_req_valid,
    input  logic      ext_req_ready,
    input  core_rsp_t ext_rsp,
    input  logic      ext_rsp_valid,
    output logic      ext_rsp_ready
);

    logic [ADDR_BITS-1:0] offset;
    logic                 hit;
    logic                 ext_lock;
    logic                 pick_smem;

    // Offset into the window is also the local index
    assign offset = in_req.addr - SMEM_BASE;
    assign hit    = (in_req.addr >= SMEM_BASE) && (offset < ADDR_BITS'(SMEM_WORDS));

    always_comb begin
        smem_req      = in_req;
        smem_req.addr = offset;
    end

    assign smem_req_valid = in_req_valid && hit;
    assign ext_req        = in_req;
    assign ext_req_valid  = in_req_valid && !hit;
    assign in_req_ready   = hit ? smem_req_ready : ext_req_ready;

    // Scratchpad wins, unless an external response is already on show
    assign pick_smem      = smem_rsp_valid && !ext_lock;
    assign in_rsp         = pick_smem ? smem_rsp : ext_rsp;
    assign in_rsp_valid   = smem_rsp_valid || ext_rsp_valid;
    assign smem_rsp_ready = in_rsp_ready && pick_smem;
    assign ext_rsp_ready  = in_rsp_ready && !pick_smem;

    always_ff @(posedge clk) begin
        if (reset) begin
            ext_lock <= 1'b0;
        end else begin
            ext_lock <= ext_rsp_valid && !pick_smem && !in_rsp_ready;
        end
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        in_rsp_valid && !in_rsp_ready |=> in_rsp_valid && $stable(in_rsp));

endmodule

/* shared_mem.sv */
`timescale 1ns/1ps

module shared_mem import mem_unit_pkg::*; #(
    parameter int SMEM_WORDS = mem_unit_pkg::SMEM_WORDS
) (
    input  logic      clk,
    input  logic      reset,

    input  core_req_t req,
    input  logic      req_valid,
    output logic      req_ready,

    output core_rsp_t rsp,
    output logic      rsp_valid,
    input  logic      rsp_ready
);

    localparam int IDX_BITS = (SMEM_WORDS > 1) ? $clog2(SMEM_WORDS) : 1;

    logic [WORD_BITS-1:0] mem [SMEM_WORDS];
    logic [IDX_BITS-1:0]  idx;
    logic                 req_fire;

    assign idx       = req.addr[IDX_BITS-1:0];
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (req_fire && req.rw) begin
            mem[idx] <= req.data;
        end
    end

    // Response payload, loaded on accepted reads only
    always_ff @(posedge clk) begin
        if (req_fire && !req.rw) begin
            rsp.data <= mem[idx];
            rsp.tag  <= req.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (req_fire && !req.rw) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // Router must hand over an index already inside the bank
    a_idx_range: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> req.addr < ADDR_BITS'(SMEM_WORDS));

endmodule

/* mem_arb.sv */
`timescale 1ns/1ps

module mem_arb import mem_unit_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    input  core_req_t fetch_req,
    input  logic      fetch_req_valid,
    output logic      fetch_req_ready,
    output core_rsp_t fetch_rsp,
    output logic      fetch_rsp_valid,
    input  logic      fetch_rsp_ready,

    input  core_req_t data_req,
    input  logic      data_req_valid,
    output logic      data_req_ready,
    output core_rsp_t data_rsp,
    output logic      data_rsp_valid,
    input  logic      data_rsp_ready,

    output mem_req_t  mem_req,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,
    input  mem_rsp_t  mem_rsp,
    input  logic      mem_rsp_valid,
    output logic      mem_rsp_ready
);

    logic prio;         // 1 gives data the first claim
    logic hold;
    logic hold_data;
    logic grant_data;
    logic rsp_src;

    // A stalled grant stays put so the request payload holds
    always_comb begin
        if (hold) begin
            grant_data = hold_data;
        end else if (data_req_valid && fetch_req_valid) begin
            grant_data = prio;
        end else begin
            grant_data = data_req_valid;
        end
    end

    always_comb begin
        if (grant_data) begin
            mem_req.rw   = data_req.rw;
            mem_req.addr = data_req.addr;
            mem_req.data = data_req.data;
            mem_req.tag  = {1'b1, data_req.tag};
        end else begin
            mem_req.rw   = 1'b0;
            mem_req.addr = fetch_req.addr;
            mem_req.data = fetch_req.data;
            mem_req.tag  = {1'b0, fetch_req.tag};
        end
    end

    assign mem_req_valid   = fetch_req_valid || data_req_valid;
    assign data_req_ready  = mem_req_ready && grant_data;
    assign fetch_req_ready = mem_req_ready && !grant_data && fetch_req_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            prio      <= 1'b0;
            hold      <= 1'b0;
            hold_data <= 1'b0;
        end else begin
            if (mem_req_valid && mem_req_ready) begin
                prio <= !grant_data;
            end
            hold      <= mem_req_valid && !mem_req_ready;
            hold_data <= grant_data;
        end
    end

    // Source bit steers the response and is dropped on the way back
    assign rsp_src         = mem_rsp.tag[MEM_TAG_BITS-1];
    assign data_rsp.data   = mem_rsp.data;
    assign data_rsp.tag    = mem_rsp.tag[TAG_BITS-1:0];
    assign fetch_rsp.data  = mem_rsp.data;
    assign fetch_rsp.tag   = mem_rsp.tag[TAG_BITS-1:0];
    assign data_rsp_valid  = mem_rsp_valid && rsp_src;
    assign fetch_rsp_valid = mem_rsp_valid && !rsp_src;
    assign mem_rsp_ready   = rsp_src ? data_rsp_ready : fetch_rsp_ready;

    // One ready at most, and only to a source that is still asking
    a_one_grant: assert property (@(posedge clk) disable iff (reset)
        $onehot0({fetch_req_ready, data_req_ready}) && (!data_req_ready || data_req_valid));

endmodule

/* mem_perf.sv */
`timescale 1ns/1ps

module mem_perf import mem_unit_pkg::*; (
    input  logic  clk,
    input  logic  reset,

    input  logic  mem_req_valid,
    input  logic  mem_req_ready,
    input  logic  mem_req_rw,
    input  logic  mem_rsp_valid,
    input  logic  mem_rsp_ready,

    output perf_t perf
);

    logic [PERF_BITS-1:0] outstanding;
    logic                 req_fire;
    logic                 rd_fire;
    logic                 rsp_fire;

    assign req_fire = mem_req_valid && mem_req_ready;
    assign rd_fire  = req_fire && !mem_req_rw;
    assign rsp_fire = mem_rsp_valid && mem_rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            perf        <= '0;
            outstanding <= '0;
        end else begin
            if (rd_fire) begin
                perf.reads <= perf.reads + PERF_BITS'(1);
            end
            if (req_fire && mem_req_rw) begin
                perf.writes <= perf.writes + PERF_BITS'(1);
            end
            if (mem_req_valid && !mem_req_ready) begin
                perf.stalls <= perf.stalls + PERF_BITS'(1);
            end
            // Reads in flight during this cycle
            perf.latency <= perf.latency + outstanding;
            outstanding  <= outstanding + PERF_BITS'(rd_fire) - PERF_BITS'(rsp_fire);
        end
    end

endmodule

/* mem_unit.sv */
`timescale 1ns/1ps

module mem_unit import mem_unit_pkg::*; #(
    parameter logic [ADDR_BITS-1:0] SMEM_BASE  = mem_unit_pkg::SMEM_BASE,
    parameter int                   SMEM_WORDS = mem_unit_pkg::SMEM_WORDS
) (
    input  logic      clk,
    input  logic      reset,

    input  core_req_t fetch_req,
    input  logic      fetch_req_valid,
    output logic      fetch_req_ready,
    output core_rsp_t fetch_rsp,
    output logic      fetch_rsp_valid,
    input  logic      fetch_rsp_ready,

    input  core_req_t data_req,
    input  logic      data_req_valid,
    output logic      data_req_ready,
    output core_rsp_t data_rsp,
    output logic      data_rsp_valid,
    input  logic      data_rsp_ready,

    output mem_req_t  mem_req,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,
    input  mem_rsp_t  mem_rsp,
    input  logic      mem_rsp_valid,
    output logic      mem_rsp_ready,

    output perf_t     perf
);

    core_req_t smem_req;
    logic      smem_req_valid;
    logic      smem_req_ready;
    core_rsp_t smem_rsp;
    logic      smem_rsp_valid;
    logic      smem_rsp_ready;

    core_req_t ext_req;
    logic      ext_req_valid;
    logic      ext_req_ready;
    core_rsp_t ext_rsp;
    logic      ext_rsp_valid;
    logic      ext_rsp_ready;

    smem_router #(
        .SMEM_BASE  (SMEM_BASE),
        .SMEM_WORDS (SMEM_WORDS)
    ) router (
        .clk            (clk),
        .reset          (reset),
        .in_req         (data_req),
        .in_req_valid   (data_req_valid),
        .in_req_ready   (data_req_ready),
        .in_rsp         (data_rsp),
        .in_rsp_valid   (data_rsp_valid),
        .in_rsp_ready   (data_rsp_ready),
        .smem_req       (smem_req),
        .smem_req_valid (smem_req_valid),
        .smem_req_ready (smem_req_ready),
        .smem_rsp       (smem_rsp),
        .smem_rsp_valid (smem_rsp_valid),
        .smem_rsp_ready (smem_rsp_ready),
        .ext_req        (ext_req),
        .ext_req_valid  (ext_req_valid),
        .ext_req_ready  (ext_req_ready),
        .ext_rsp        (ext_rsp),
        .ext_rsp_valid  (ext_rsp_valid),
        .ext_rsp_ready  (ext_rsp_ready)
    );

    shared_mem #(
        .SMEM_WORDS (SMEM_WORDS)
    ) smem (
        .clk       (clk),
        .reset     (reset),
        .req       (smem_req),
        .req_valid (smem_req_valid),
        .req_ready (smem_req_ready),
        .rsp       (smem_rsp),
        .rsp_valid (smem_rsp_valid),
        .rsp_ready (smem_rsp_ready)
    );

    mem_arb arb (
        .clk             (clk),
        .reset           (reset),
        .fetch_req       (fetch_req),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req_ready (fetch_req_ready),
        .fetch_rsp       (fetch_rsp),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp_ready (fetch_rsp_ready),
        .data_req        (ext_req),
        .data_req_valid  (ext_req_valid),
        .data_req_ready  (ext_req_ready),
        .data_rsp        (ext_rsp),
        .data_rsp_valid  (ext_rsp_valid),
        .data_rsp_ready  (ext_rsp_ready),
        .mem_req         (mem_req),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp         (mem_rsp),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_ready   (mem_rsp_ready)
    );

    mem_perf counters (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_rw    (mem_req.rw),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .perf          (perf)
    );

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker import mem_unit_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  core_req_t fetch_req,
    input  logic      fetch_req_valid,
    input  logic      fetch_req_ready,
    input  core_rsp_t fetch_rsp,
    input  logic      fetch_rsp_valid,
    input  logic      fetch_rsp_ready,
    input  core_req_t data_req,
    input  logic      data_req_valid,
    input  logic      data_req_ready,
    input  core_rsp_t data_rsp,
    input  logic      data_rsp_valid,
    input  logic      data_rsp_ready,
    input  mem_req_t  mem_req,
    input  logic      mem_req_valid,
    input  logic      mem_req_ready,
    input  logic      mem_rsp_valid,
    input  logic      mem_rsp_ready,
    input  perf_t     perf,
    input  logic      test_done,
    input  int        test_idx,
    output int        pending,
    output int        errors,
    output int        checks
);

    string names[6] = '{"scratchpad", "external", "fetch", "arbitration",
                        "backpressure", "counters"};

    logic [WORD_BITS-1:0] shadow [logic [ADDR_BITS-1:0]];
    logic [WORD_BITS-1:0] data_exp [int];
    logic [WORD_BITS-1:0] fetch_exp [int];
    int                   data_acc [int];
    bit                   data_smem [int];
    int  cycle = 0;
    int  test_errs = 0;
    int  n_rd = 0;
    int  n_wr = 0;
    int  n_st = 0;
    int  outs = 0;
    longint lat = 0;
    bit  have_prev = 0;
    bit  prev_src;
    bit  mreq_stall = 0;
    bit  drsp_stall = 0;
    bit  both_at_grant = 0;
    bit  src_data;
    bit  fetch_xfer;
    mem_req_t  prev_mreq;
    core_rsp_t prev_drsp;

    initial begin
        pending = 0;
        errors  = 0;
        checks  = 0;
    end

    function automatic logic [WORD_BITS-1:0] ref_word(logic [ADDR_BITS-1:0] a);
        return shadow.exists(a) ? shadow[a] : ({2'b00, a} ^ 32'hC3A5_0F1E);
    endfunction

    function automatic bit in_window(logic [ADDR_BITS-1:0] a);
        return a >= SMEM_BASE && a < SMEM_BASE + SMEM_WORDS;
    endfunction

    task automatic compare(string what, longint exp, longint act);
        checks++;
        if (exp != act) begin
            $display("** Error [%s] %s expected %h actual %h", names[test_idx], what, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic complain(string msg);
        $display("Failure in test %s: %s", names[test_idx], msg);
        errors++;
        test_errs++;
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            cycle++;
            if (mreq_stall && !(mem_req_valid && mem_req == prev_mreq))
                complain("external request changed while stalled");
            if (drsp_stall && !(data_rsp_valid && data_rsp == prev_drsp))
                complain("data response changed while held");
            if (data_req_valid && data_req_ready) begin
                if (data_req.rw) begin
                    shadow[data_req.addr] = data_req.data;
                end else begin
                    data_exp[data_req.tag]  = ref_word(data_req.addr);
                    data_acc[data_req.tag]  = cycle;
                    data_smem[data_req.tag] = in_window(data_req.addr);
                    pending++;
                end
            end
            if (fetch_req_valid && fetch_req_ready) begin
                fetch_exp[fetch_req.tag] = ref_word(fetch_req.addr);
                pending++;
            end
            // Grant is chosen afresh in the first cycle of an external request
            if (mem_req_valid && !mreq_stall)
                both_at_grant = fetch_req_valid && data_req_valid && !in_window(data_req.addr);
            if (mem_req_valid && mem_req_ready) begin
                src_data   = data_req_valid && data_req_ready && !in_window(data_req.addr);
                fetch_xfer = fetch_req_valid && fetch_req_ready;
                if (src_data == fetch_xfer)
                    complain("external transfer not taken from exactly one source");
                compare("source bit", src_data, mem_req.tag[MEM_TAG_BITS-1]);
                if (fetch_xfer) compare("fetch rw", 0, mem_req.rw);
                if (both_at_grant && have_prev && prev_src == src_data)
                    complain("grant did not alternate with both sources valid");
                have_prev = 1'b1;
                prev_src  = src_data;
                if (mem_req.rw) n_wr++;
                else n_rd++;
            end
            if (data_rsp_valid && data_rsp_ready) begin
                if (!data_exp.exists(data_rsp.tag)) begin
                    complain($sformatf("unexpected data response, tag %0d", data_rsp.tag));
                end else begin
                    compare("data response", data_exp[data_rsp.tag], data_rsp.data);
                    if (test_idx == 0 && data_smem[data_rsp.tag])
                        compare("scratchpad latency", 1, cycle - data_acc[data_rsp.tag]);
                    data_exp.delete(data_rsp.tag);
                    pending--;
                end
            end
            if (fetch_rsp_valid && fetch_rsp_ready) begin
                if (!fetch_exp.exists(fetch_rsp.tag)) begin
                    complain($sformatf("unexpected fetch response, tag %0d", fetch_rsp.tag));
                end else begin
                    compare("fetch response", fetch_exp[fetch_rsp.tag], fetch_rsp.data);
                    fetch_exp.delete(fetch_rsp.tag);
                    pending--;
                end
            end
            // Latency adds the reads in flight during this cycle
            lat += outs;
            outs += (mem_req_valid && mem_req_ready && !mem_req.rw)
                    - (mem_rsp_valid && mem_rsp_ready);
            if (mem_req_valid && !mem_req_ready) n_st++;
            mreq_stall = mem_req_valid && !mem_req_ready;
            drsp_stall = data_rsp_valid && !data_rsp_ready;
            prev_mreq  = mem_req;
            prev_drsp  = data_rsp;
            if (test_done) begin
                if (test_idx == 5) begin
                    compare("perf reads", n_rd, perf.reads);
                    compare("perf writes", n_wr, perf.writes);
                    compare("perf stalls", n_st, perf.stalls);
                    compare("perf latency", lat[PERF_BITS-1:0], perf.latency);
                end
                $display("test %0d %s: %s", test_idx, names[test_idx],
                         test_errs == 0 ? "passed" : "had errors");
                test_errs = 0;
            end
        end
    end

endmodule

/* tb_mem_unit.sv */
`timescale 1ns/1ps

module tb_mem_unit import mem_unit_pkg::*; ();

    localparam int TOTAL_REQ = 80;

    logic      clk;
    logic      reset;
    core_req_t fetch_req;
    logic      fetch_req_valid;
    logic      fetch_req_ready;
    core_rsp_t fetch_rsp;
    logic      fetch_rsp_valid;
    logic      fetch_rsp_ready;
    core_req_t data_req;
    logic      data_req_valid;
    logic      data_req_ready;
    core_rsp_t data_rsp;
    logic      data_rsp_valid;
    logic      data_rsp_ready;
    mem_req_t  mem_req;
    logic      mem_req_valid;
    logic      mem_req_ready;
    mem_rsp_t  mem_rsp;
    logic      mem_rsp_valid;
    logic      mem_rsp_ready;
    perf_t     perf;

    logic      test_done;
    int        test_idx;
    int        pending;
    int        errors;
    int        checks;
    logic      bp;
    int        cycle;
    logic      data_fired;
    logic      fetch_fired;
    logic      rsp_fired;

    core_req_t            data_q[$];
    core_req_t            fetch_q[$];
    int                   pend_due[$];
    mem_rsp_t             pend_rsp[$];
    logic [WORD_BITS-1:0] ext_mem [logic [ADDR_BITS-1:0]];

    mem_unit #(
        .SMEM_BASE  (SMEM_BASE),
        .SMEM_WORDS (SMEM_WORDS)
    ) u_mem_unit (.*);

    tb_checker u_check (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic core_req_t make_req(logic rw, logic [ADDR_BITS-1:0] addr,
                                           logic [WORD_BITS-1:0] data, int tag);
        core_req_t r;
        r.rw   = rw;
        r.addr = addr;
        r.data = data;
        r.tag  = tag[TAG_BITS-1:0];
        return r;
    endfunction

    always @(posedge clk) begin
        data_fired  <= data_req_valid && data_req_ready;
        fetch_fired <= fetch_req_valid && fetch_req_ready;
        rsp_fired   <= mem_rsp_valid && mem_rsp_ready;
        cycle       <= cycle + 1;
        // External memory takes the word at acceptance
        if (!reset && mem_req_valid && mem_req_ready) begin
            if (mem_req.rw) begin
                ext_mem[mem_req.addr] = mem_req.data;
            end else begin
                pend_due.push_back(cycle + 1 + int'($urandom % 6));
                pend_rsp.push_back({ext_mem.exists(mem_req.addr) ? ext_mem[mem_req.addr]
                                    : ({2'b00, mem_req.addr} ^ 32'hC3A5_0F1E), mem_req.tag});
            end
        end
    end

    // Request drivers, memory model and ready lines all move on the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (!data_req_valid || data_fired) begin
                data_req_valid = data_q.size() > 0;
                if (data_req_valid) data_req = data_q.pop_front();
            end
            if (!fetch_req_valid || fetch_fired) begin
                fetch_req_valid = fetch_q.size() > 0;
                if (fetch_req_valid) fetch_req = fetch_q.pop_front();
            end
            if (mem_rsp_valid && rsp_fired) mem_rsp_valid = 1'b0;
            if (!mem_rsp_valid) begin
                for (int i = 0; i < pend_due.size(); i++) begin
                    if (!mem_rsp_valid && pend_due[i] <= cycle) begin
                        mem_rsp       = pend_rsp[i];
                        mem_rsp_valid = 1'b1;
                        pend_due.delete(i);
                        pend_rsp.delete(i);
                    end
                end
            end
            mem_req_ready   = ($urandom % 4) != 0;
            data_rsp_ready  = !bp || (($urandom % 3) != 0);
            fetch_rsp_ready = !bp || (($urandom % 3) != 0);
        end
    end

    task automatic finish_test();
        do @(negedge clk);
        while (data_q.size() > 0 || fetch_q.size() > 0 || data_req_valid
               || fetch_req_valid || pending != 0);
        repeat (3) @(negedge clk);
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
        test_idx  = test_idx + 1;
    endtask

    initial begin
        void'($urandom(73414));
        reset = 1'b1;
        cycle = 0;
        {fetch_req, fetch_req_valid, data_req, data_req_valid} = '0;
        {mem_rsp, mem_rsp_valid, mem_req_ready} = '0;
        {fetch_rsp_ready, data_rsp_ready, bp, test_done} = '0;
        test_idx = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < 8; i++) data_q.push_back(make_req(1, SMEM_BASE + i * 5, $urandom, i));
        for (int i = 0; i < 8; i++) data_q.push_back(make_req(0, SMEM_BASE + i * 5, 0, i));
        finish_test();
        for (int i = 0; i < 4; i++) data_q.push_back(make_req(1, 'h100 + i, $urandom, i));
        for (int i = 0; i < 8; i++) data_q.push_back(make_req(0, 'h100 + i, 0, i));
        finish_test();
        for (int i = 0; i < 8; i++) fetch_q.push_back(make_req(1, 'h2000 + i, 0, i));
        finish_test();
        for (int i = 0; i < 8; i++) begin
            fetch_q.push_back(make_req(0, 'h2100 + i, 0, i));
            data_q.push_back(make_req(0, 'h300 + i, 0, i + 8));
        end
        finish_test();
        bp = 1'b1;
        for (int i = 0; i < 12; i++) begin
            if ($urandom % 2) data_q.push_back(make_req($urandom % 2,
                SMEM_BASE + ($urandom % 8) * 5, $urandom, i));
            else data_q.push_back(make_req($urandom % 2, 'h100 + $urandom % 16, $urandom, i));
        end
        for (int i = 0; i < 8; i++) fetch_q.push_back(make_req(0, 'h2000 + $urandom % 8, 0, i));
        finish_test();
        for (int i = 0; i < 8; i++) data_q.push_back(make_req(i % 2, 'h400 + i, $urandom, i));
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", test_idx, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (8 + TOTAL_REQ * 20) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TOTAL_REQ * 20);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* verilog.f */
mem_unit_pkg.sv
smem_router.sv
shared_mem.sv
mem_arb.sv
mem_perf.sv
mem_unit.sv
tb_checker.sv
tb_mem_unit.sv
